/* logic/hsid_defines.svh */
`ifndef HSID_DEFINES_SVH
`define HSID_DEFINES_SVH

`define HSID_SAMPLE_WIDTH   16  // One band sample
`define HSID_BANDS_WIDTH    7   // Up to 64 bands
`define HSID_LIBRARY_WIDTH  8   // Up to 255 references
`define HSID_SCORE_WIDTH    40  // Sum of squares over all bands
`define HSID_REF_FIFO_DEPTH 8   // Reference packs
`define HSID_CAPT_DEPTH     32  // Captured packs, two bands each
`define HSID_ADR_WIDTH      4   // Wishbone word address

// Register map, word addresses
`define HSID_REG_CTRL       4'd0  // Bit 0 start, bit 1 clear
`define HSID_REG_BANDS      4'd1
`define HSID_REG_LIB_SIZE   4'd2
`define HSID_REG_CAPT_DATA  4'd3  // Push one captured pack
`define HSID_REG_REF_DATA   4'd4  // Push one reference pack
`define HSID_REG_STATUS     4'd5  // Bit 0 idle, bit 1 result_valid
`define HSID_REG_BEST_INDEX 4'd6
`define HSID_REG_SCORE_LO   4'd7
`define HSID_REG_SCORE_HI   4'd8

`endif

/* logic/hsid_pkg.sv */
`include "hsid_defines.svh"

package hsid_pkg;

  // Search sequencing
  typedef enum logic [2:0] {
    MAIN_IDLE,
    MAIN_CONFIG,
    COMPUTE_MSE,
    WAIT_MSE,
    DONE,
    MAIN_CLEAR
  } hsid_main_state_t;

  // Two bands per Wishbone word
  typedef struct packed {
    logic [`HSID_SAMPLE_WIDTH-1:0] lane1;  // Odd band
    logic [`HSID_SAMPLE_WIDTH-1:0] lane0;  // Even band
  } band_pack_t;

  // One pack pair on its way into the score pipeline
  typedef struct packed {
    band_pack_t                     capt;
    band_pack_t                     ref_pk;
    logic                           lane1_valid;  // Low on the odd tail band
    logic                           last;         // Last pack of this reference
    logic                           lib_last;     // Last reference of the library
    logic [`HSID_LIBRARY_WIDTH-1:0] ref_index;
  } pack_beat_t;

  // Finished score of one reference
  typedef struct packed {
    logic [`HSID_SCORE_WIDTH-1:0]   score;
    logic [`HSID_LIBRARY_WIDTH-1:0] ref_index;
    logic                           lib_last;
  } mse_result_t;

endpackage

/* logic/hsid_wb_regs.sv */
`include "hsid_defines.svh"

module hsid_wb_regs (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             cyc,
  input  logic                             stb,
  input  logic                             we,
  input  logic [`HSID_ADR_WIDTH-1:0]       adr,
  input  logic [31:0]                      dat_w,
  input  logic                             ref_full,
  input  logic                             idle,
  input  logic                             result_valid,
  input  logic [`HSID_LIBRARY_WIDTH-1:0]   best_index,
  input  logic [`HSID_SCORE_WIDTH-1:0]     best_score,
  output logic [31:0]                      dat_r,
  output logic                             ack,
  output logic [`HSID_BANDS_WIDTH-1:0]     bands,
  output logic [`HSID_LIBRARY_WIDTH-1:0]   lib_size,
  output logic                             start_pulse,
  output logic                             clear_pulse,
  output logic                             capt_wr,
  output hsid_pkg::band_pack_t             capt_data,
  output logic                             ref_push,
  output hsid_pkg::band_pack_t             ref_data
);

  logic        stall;   // Reference push into a full FIFO
  logic        accept;  // Request taken this cycle
  logic        wr_en;
  logic [31:0] rd_mux;

  assign stall  = we && adr == `HSID_REG_REF_DATA && ref_full;
  assign accept = cyc && stb && !ack && !stall;  // !ack keeps one access per request
  assign wr_en  = accept && we;

  // Data pushes go straight through in the accept cycle
  assign capt_wr   = wr_en && adr == `HSID_REG_CAPT_DATA;
  assign capt_data = dat_w;
  assign ref_push  = wr_en && adr == `HSID_REG_REF_DATA;
  assign ref_data  = dat_w;

  always_comb begin
    rd_mux = '0;
    case (adr)
      `HSID_REG_BANDS:      rd_mux[`HSID_BANDS_WIDTH-1:0] = bands;
      `HSID_REG_LIB_SIZE:   rd_mux[`HSID_LIBRARY_WIDTH-1:0] = lib_size;
      `HSID_REG_STATUS:     rd_mux[1:0] = {result_valid, idle};
      `HSID_REG_BEST_INDEX: rd_mux[`HSID_LIBRARY_WIDTH-1:0] = best_index;
      `HSID_REG_SCORE_LO:   rd_mux = best_score[31:0];
      `HSID_REG_SCORE_HI:   rd_mux[`HSID_SCORE_WIDTH-33:0] = best_score[`HSID_SCORE_WIDTH-1:32];
      default:              rd_mux = '0;  // CTRL and the data ports read as zero
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack         <= 1'b0;
      dat_r       <= '0;
      bands       <= '0;
      lib_size    <= '0;
      start_pulse <= 1'b0;
      clear_pulse <= 1'b0;
    end else begin
      ack         <= accept;  // Single-cycle ack after the request
      start_pulse <= wr_en && adr == `HSID_REG_CTRL && dat_w[0];
      clear_pulse <= wr_en && adr == `HSID_REG_CTRL && dat_w[1];
      if (wr_en && adr == `HSID_REG_BANDS)
        bands <= dat_w[`HSID_BANDS_WIDTH-1:0];
      if (wr_en && adr == `HSID_REG_LIB_SIZE)
        lib_size <= dat_w[`HSID_LIBRARY_WIDTH-1:0];
      if (accept && !we)
        dat_r <= rd_mux;  // Held until the next read
    end
  end

endmodule

/* logic/hsid_captured_buf.sv */
`include "hsid_defines.svh"

module hsid_captured_buf (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                wr,
  input  hsid_pkg::band_pack_t                wr_data,
  input  logic                                rewind,
  input  logic [$clog2(`HSID_CAPT_DEPTH)-1:0] rd_addr,
  output hsid_pkg::band_pack_t                rd_data
);
  import hsid_pkg::*;

  band_pack_t                          mem [`HSID_CAPT_DEPTH];
  logic [$clog2(`HSID_CAPT_DEPTH)-1:0] wr_ptr;

  // Host fills packs in band order from address zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)     wr_ptr <= '0;
    else if (rewind) wr_ptr <= '0;  // Start or clear
    else if (wr)     wr_ptr <= wr_ptr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (wr)
      mem[wr_ptr] <= wr_data;
    rd_data <= mem[rd_addr];  // Lines up with the FIFO's registered pop
  end

endmodule

/* logic/hsid_fifo.sv */
module hsid_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 flush,
  input  logic                 push,
  input  hsid_pkg::band_pack_t push_data,
  input  logic                 pop,
  output hsid_pkg::band_pack_t pop_data,
  output logic                 full,
  output logic                 empty
);
  import hsid_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  band_pack_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign full    = count == (PTR_W+1)'(DEPTH);
  assign empty   = count == '0;
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin  // Flush drops everything queued
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
    if (do_pop)  pop_data    <= mem[rd_ptr];  // Valid the cycle after pop
  end

endmodule

/* logic/hsid_main_fsm.sv */
`include "hsid_defines.svh"

module hsid_main_fsm (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                start,
  input  logic                                clear,
  input  logic [`HSID_BANDS_WIDTH-1:0]        bands,
  input  logic [`HSID_LIBRARY_WIDTH-1:0]      lib_size,
  input  logic                                fifo_empty,
  input  hsid_pkg::band_pack_t                capt_data,
  input  hsid_pkg::band_pack_t                ref_data,
  input  logic                                search_done,
  output logic                                fifo_rd,
  output logic                                fifo_flush,
  output logic                                capt_rewind,
  output logic [$clog2(`HSID_CAPT_DEPTH)-1:0] capt_addr,
  output hsid_pkg::pack_beat_t                beat,
  output logic                                beat_valid,
  output logic                                idle
);
  import hsid_pkg::*;

  hsid_main_state_t               state;
  hsid_main_state_t               state_nxt;
  logic [`HSID_BANDS_WIDTH-1:0]   cfg_bands;
  logic [`HSID_LIBRARY_WIDTH-1:0] cfg_lib_size;
  logic [`HSID_BANDS_WIDTH-1:0]   cfg_pack_threshold;  // Packs per reference
  logic [`HSID_BANDS_WIDTH-1:0]   band_pack_count;
  logic [`HSID_LIBRARY_WIDTH-1:0] hsp_ref_count;
  logic                           pack_last;
  logic                           ref_last;
  logic                           tag_last;
  logic                           tag_lib_last;
  logic                           tag_lane1_valid;
  logic [`HSID_LIBRARY_WIDTH-1:0] tag_index;

  assign pack_last   = band_pack_count == cfg_pack_threshold - 1'b1;
  assign ref_last    = hsp_ref_count == cfg_lib_size - 1'b1;
  assign fifo_rd     = state == COMPUTE_MSE && !fifo_empty && !clear;  // Stall on empty
  assign fifo_flush  = state == MAIN_CLEAR;
  assign capt_rewind = (state == MAIN_IDLE && start) || state == MAIN_CLEAR;
  assign capt_addr   = band_pack_count[$clog2(`HSID_CAPT_DEPTH)-1:0];
  assign idle        = state == MAIN_IDLE;

  // Both reads landed this cycle, tags were registered alongside
  assign beat = '{capt: capt_data, ref_pk: ref_data, lane1_valid: tag_lane1_valid,
                  last: tag_last, lib_last: tag_lib_last, ref_index: tag_index};

  always_comb begin
    state_nxt = state;
    case (state)
      MAIN_IDLE:   if (start) state_nxt = MAIN_CONFIG;
      MAIN_CONFIG: state_nxt = COMPUTE_MSE;
      COMPUTE_MSE: if (fifo_rd && pack_last && ref_last) state_nxt = WAIT_MSE;
      WAIT_MSE:    if (search_done) state_nxt = DONE;  // Last score compared
      DONE:        state_nxt = MAIN_IDLE;
      default:     state_nxt = MAIN_IDLE;
    endcase
    if (clear && state != MAIN_CLEAR)
      state_nxt = MAIN_CLEAR;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state              <= MAIN_IDLE;
      cfg_bands          <= '0;
      cfg_lib_size       <= '0;
      cfg_pack_threshold <= '0;
      band_pack_count    <= '0;
      hsp_ref_count      <= '0;
      beat_valid         <= 1'b0;
      tag_last           <= 1'b0;
      tag_lib_last       <= 1'b0;
      tag_lane1_valid    <= 1'b0;
      tag_index          <= '0;
    end else begin
      state <= state_nxt;

      // Entering clear sends a void beat so a half-summed reference is dropped
      beat_valid      <= fifo_rd || (clear && state != MAIN_CLEAR);
      tag_last        <= fifo_rd && pack_last;
      tag_lib_last    <= fifo_rd && pack_last && ref_last;
      tag_lane1_valid <= !(pack_last && cfg_bands[0]);  // Odd count masks tail lane
      tag_index       <= fifo_rd ? hsp_ref_count : '1;  // All ones is never a live index

      case (state)
        MAIN_CONFIG: begin
          cfg_bands          <= bands;
          cfg_lib_size       <= lib_size;
          cfg_pack_threshold <= (bands >> 1) + `HSID_BANDS_WIDTH'(bands[0]);  // Round up
          band_pack_count    <= '0;
          hsp_ref_count      <= '0;
        end
        COMPUTE_MSE: begin
          if (fifo_rd && pack_last) begin
            band_pack_count <= '0;
            hsp_ref_count   <= hsp_ref_count + 1'b1;
          end else if (fifo_rd) begin
            band_pack_count <= band_pack_count + 1'b1;
          end
        end
        DONE, MAIN_CLEAR: begin
          band_pack_count <= '0;
          hsp_ref_count   <= '0;
        end
        default: ;
      endcase
    end
  end

endmodule

/* logic/hsid_mse_unit.sv */
`include "hsid_defines.svh"

module hsid_mse_unit (
  input  logic                  clk,
  input  logic                  arst_n,
  input  hsid_pkg::pack_beat_t  beat,
  input  logic                  beat_valid,
  output hsid_pkg::mse_result_t result,
  output logic                  mse_valid
);
  import hsid_pkg::*;

  localparam int DW = `HSID_SAMPLE_WIDTH + 1;  // Signed lane difference
  localparam int SW = 2 * DW;                  // Square

  // Per-beat bookkeeping that rides along the stages
  typedef struct packed {
    logic                           last;
    logic                           lib_last;
    logic [`HSID_LIBRARY_WIDTH-1:0] ref_index;
  } tag_t;

  logic                           s1_valid, s2_valid, s3_valid;
  tag_t                           s1_tag, s2_tag, s3_tag;
  logic signed [DW-1:0]           s1_diff0, s1_diff1;
  logic                           s1_lane1;
  logic [SW-1:0]                  s2_sq0, s2_sq1;
  logic [SW:0]                    s3_sum;
  logic [`HSID_SCORE_WIDTH-1:0]   acc;
  logic [`HSID_SCORE_WIDTH-1:0]   acc_nxt;
  logic                           acc_done;   // Previous reference closed
  logic [`HSID_LIBRARY_WIDTH-1:0] acc_index;
  logic                           restart;

  // New reference when the old one closed or the index moved on
  assign restart = acc_done || s3_tag.ref_index != acc_index;
  assign acc_nxt = (restart ? '0 : acc) + `HSID_SCORE_WIDTH'(s3_sum);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      s3_valid  <= 1'b0;
      mse_valid <= 1'b0;
      acc_done  <= 1'b1;
      acc_index <= '0;
    end else begin
      s1_valid  <= beat_valid;
      s2_valid  <= s1_valid;
      s3_valid  <= s2_valid;
      mse_valid <= s3_valid && s3_tag.last;  // Four cycles after the last beat
      if (s3_valid) begin
        acc_done  <= s3_tag.last;
        acc_index <= s3_tag.ref_index;
      end
    end
  end

  always_ff @(posedge clk) begin
    // Stage 1 lane differences
    s1_diff0 <= $signed({1'b0, beat.capt.lane0}) - $signed({1'b0, beat.ref_pk.lane0});
    s1_diff1 <= $signed({1'b0, beat.capt.lane1}) - $signed({1'b0, beat.ref_pk.lane1});
    s1_lane1 <= beat.lane1_valid;
    s1_tag   <= '{last: beat.last, lib_last: beat.lib_last, ref_index: beat.ref_index};
    // Stage 2 squares
    s2_sq0 <= s1_diff0 * s1_diff0;
    if (s1_lane1)
      s2_sq1 <= s1_diff1 * s1_diff1;
    else
      s2_sq1 <= '0;  // Odd tail band
    s2_tag <= s1_tag;
    // Stage 3 lane sum
    s3_sum <= s2_sq0 + s2_sq1;
    s3_tag <= s2_tag;
    // Stage 4 accumulate
    if (s3_valid) acc <= acc_nxt;
    if (s3_valid && s3_tag.last)
      result <= '{score: acc_nxt, ref_index: s3_tag.ref_index, lib_last: s3_tag.lib_last};
  end

endmodule

/* logic/hsid_min_select.sv */
`include "hsid_defines.svh"

module hsid_min_select (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           clear_best,
  input  hsid_pkg::mse_result_t          result,
  input  logic                           mse_valid,
  output logic [`HSID_LIBRARY_WIDTH-1:0] best_index,
  output logic [`HSID_SCORE_WIDTH-1:0]   best_score,
  output logic                           result_valid,
  output logic                           search_done
);

  logic have_best;  // A score was taken since the last start

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      have_best    <= 1'b0;
      best_index   <= '0;
      best_score   <= '0;
      result_valid <= 1'b0;
      search_done  <= 1'b0;
    end else begin
      search_done <= mse_valid && result.lib_last && !clear_best;
      if (clear_best) begin
        have_best    <= 1'b0;
        best_score   <= '0;
        result_valid <= 1'b0;
      end else if (mse_valid) begin
        // Strictly lower only, so the earlier index keeps a tie
        if (!have_best || result.score < best_score) begin
          best_score <= result.score;
          best_index <= result.ref_index;
          have_best  <= 1'b1;
        end
        if (result.lib_last)
          result_valid <= 1'b1;  // Sticky until next start or clear
      end
    end
  end

endmodule

/* logic/hsid_top.sv */
`include "hsid_defines.svh"

module hsid_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [`HSID_ADR_WIDTH-1:0] adr,
  input  logic [31:0]                dat_w,
  output logic [31:0]                dat_r,
  output logic                       ack
);
  import hsid_pkg::*;

  logic                                ref_full, ref_empty, ref_push, ref_pop, ref_flush;
  logic                                idle, result_valid, search_done;
  logic                                start_pulse, clear_pulse;
  logic                                capt_wr, capt_rewind;
  logic [$clog2(`HSID_CAPT_DEPTH)-1:0] capt_addr;
  logic [`HSID_BANDS_WIDTH-1:0]        bands;
  logic [`HSID_LIBRARY_WIDTH-1:0]      lib_size, best_index;
  logic [`HSID_SCORE_WIDTH-1:0]        best_score;
  band_pack_t                          capt_wr_data, capt_rd_data, ref_wr_data, ref_rd_data;
  pack_beat_t                          beat;
  logic                                beat_valid, mse_valid;
  mse_result_t                         result;

  hsid_wb_regs u_regs (
    .clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .ref_full, .idle, .result_valid, .best_index, .best_score,
    .bands, .lib_size, .start_pulse, .clear_pulse,
    .capt_wr, .capt_data(capt_wr_data), .ref_push, .ref_data(ref_wr_data)
  );

  hsid_captured_buf u_capt (
    .clk, .arst_n, .wr(capt_wr), .wr_data(capt_wr_data),
    .rewind(capt_rewind), .rd_addr(capt_addr), .rd_data(capt_rd_data)
  );

  hsid_fifo #(.DEPTH(`HSID_REF_FIFO_DEPTH)) u_ref_fifo (
    .clk, .arst_n, .flush(ref_flush), .push(ref_push), .push_data(ref_wr_data),
    .pop(ref_pop), .pop_data(ref_rd_data), .full(ref_full), .empty(ref_empty)
  );

  hsid_main_fsm u_fsm (
    .clk, .arst_n, .start(start_pulse), .clear(clear_pulse), .bands, .lib_size,
    .fifo_empty(ref_empty), .capt_data(capt_rd_data), .ref_data(ref_rd_data),
    .search_done, .fifo_rd(ref_pop), .fifo_flush(ref_flush), .capt_rewind,
    .capt_addr, .beat, .beat_valid, .idle
  );

  hsid_mse_unit u_mse (
    .clk, .arst_n, .beat, .beat_valid, .result, .mse_valid
  );

  // Start and clear both reset the best-score tracking
  hsid_min_select u_min (
    .clk, .arst_n, .clear_best(capt_rewind), .result, .mse_valid,
    .best_index, .best_score, .result_valid, .search_done
  );

endmodule

/* sim/hsid_tb_tasks.svh */
`ifndef HSID_TB_TASKS_SVH
`define HSID_TB_TASKS_SVH

// One Wishbone classic access, request held until ack
task automatic bus_access(input logic write, input logic [`HSID_ADR_WIDTH-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
  int waited;
  waited = 0;
  rdata  = '0;
  cyc    = 1'b1;
  stb    = 1'b1;
  we     = write;
  adr    = addr;
  dat_w  = wdata;
  do begin
    @(posedge clk);
    #1;
    waited++;
  end while (!ack && waited < ACK_TIMEOUT);  // Long only on a full FIFO
  if (!ack) begin
    abort_run($sformatf("no ack on address %0d after %0d cycles", addr, waited));
  end else begin
    rdata         = dat_r;  // Registered together with ack
    last_ack_wait = waited;
    cyc           = 1'b0;
    stb           = 1'b0;
    we            = 1'b0;
    @(posedge clk);  // Strobe low for a cycle between accesses
    #1;
  end
endtask

task automatic write_reg(input logic [`HSID_ADR_WIDTH-1:0] addr, input logic [31:0] data);
  logic [31:0] discard;
  bus_access(1'b1, addr, data, discard);
endtask

task automatic read_reg(input logic [`HSID_ADR_WIDTH-1:0] addr, output logic [31:0] data);
  bus_access(1'b0, addr, 32'h0, data);
endtask

// Poll STATUS until every bit of mask is set
task automatic wait_status(input logic [1:0] mask, input string what,
                           output logic [31:0] status);
  int polls;
  polls = 0;
  do begin
    read_reg(`HSID_REG_STATUS, status);
    polls++;
  end while ((status[1:0] & mask) != mask && polls < POLL_LIMIT);
  if ((status[1:0] & mask) != mask)
    abort_run($sformatf("STATUS stuck at %h while waiting for %s", status, what));
endtask

// Sum of squared differences over the configured bands only
function automatic longint model_score(input int r, input int nbands);
  longint sum;
  longint d;
  sum = 0;
  for (int b = 0; b < nbands; b++) begin
    d   = longint'(capt_s[b]) - longint'(ref_s[r][b]);
    sum += d * d;
  end
  return sum;
endfunction

function automatic void model_best(input int nrefs, input int nbands,
                                   output int idx, output longint score);
  longint s;
  idx   = 0;
  score = model_score(0, nbands);
  for (int r = 1; r < nrefs; r++) begin
    s = model_score(r, nbands);
    if (s < score) begin  // Ties keep the lower index
      idx   = r;
      score = s;
    end
  end
endfunction

`endif

/* sim/hsid_tb.sv */
`include "hsid_defines.svh"

module hsid_tb;
  import hsid_pkg::*;

  localparam int SW          = `HSID_SAMPLE_WIDTH;
  localparam int ACK_TIMEOUT = 200;  // Cycles per bus access
  localparam int POLL_LIMIT  = 300;  // STATUS reads per wait
  localparam int MAX_REFS    = 8;
  localparam int MAX_BANDS   = 64;

  logic                       clk;
  logic                       arst_n;
  logic                       cyc;
  logic                       stb;
  logic                       we;
  logic [`HSID_ADR_WIDTH-1:0] adr;
  logic [31:0]                dat_w;
  logic [31:0]                dat_r;
  logic                       ack;

  logic [SW-1:0] capt_s [MAX_BANDS];            // Captured pixel with one entry per band
  logic [SW-1:0] ref_s  [MAX_REFS][MAX_BANDS];  // Reference library
  int            last_ack_wait;                 // Cycles from request to ack
  int            checks;
  int            errors;
  int            test_no;
  int            test_errors;                   // Error count when the test began

  hsid_top u_hsid_top (.clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  `include "hsid_tb_tasks.svh"

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic expect_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %0d %s: %s (%0d errors)", test_no, name,
             errors == test_errors ? "ok" : "failed", errors - test_errors);
    test_no++;
    test_errors = errors;
  endtask

  task automatic fill_random(input int nrefs);
    for (int b = 0; b < MAX_BANDS; b++) begin
      capt_s[b] = SW'($urandom);
      for (int r = 0; r < nrefs; r++)
        ref_s[r][b] = SW'($urandom);
    end
  endtask

  // Load the captured pixel and the config registers
  task automatic setup_search(input int nbands, input int nrefs);
    band_pack_t pk;
    for (int k = 0; k < (nbands + 1) / 2; k++) begin
      pk.lane0 = capt_s[2*k];
      pk.lane1 = capt_s[2*k+1];
      write_reg(`HSID_REG_CAPT_DATA, pk);
    end
    write_reg(`HSID_REG_BANDS, 32'(nbands));
    write_reg(`HSID_REG_LIB_SIZE, 32'(nrefs));
  endtask

  task automatic push_reference(input int r, input int nbands);
    band_pack_t pk;
    for (int k = 0; k < (nbands + 1) / 2; k++) begin
      pk.lane0 = ref_s[r][2*k];
      pk.lane1 = ref_s[r][2*k+1];  // Spare slot on an odd count
      write_reg(`HSID_REG_REF_DATA, pk);
    end
  endtask

  // A push into a full FIFO must see no ack before the request is withdrawn
  task automatic probe_stall();
    int seen;
    seen  = 0;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = `HSID_REG_REF_DATA;
    dat_w = 32'hdead_beef;
    for (int c = 0; c < 6; c++) begin
      @(posedge clk);
      #1;
      if (ack)
        seen++;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(posedge clk);
    #1;
    expect_word("ack_on_full_fifo", 32'(seen), 32'h0);
  endtask

  task automatic check_result(input int nrefs, input int nbands);
    int          exp_idx;
    longint      exp_score;
    logic [31:0] got;
    model_best(nrefs, nbands, exp_idx, exp_score);
    read_reg(`HSID_REG_BEST_INDEX, got);
    expect_word("best_index", got, 32'(exp_idx));
    read_reg(`HSID_REG_SCORE_LO, got);
    expect_word("score_lo", got, exp_score[31:0]);
    read_reg(`HSID_REG_SCORE_HI, got);
    expect_word("score_hi", got, 32'(exp_score[39:32]));
  endtask

  task automatic full_run(input int nbands, input int nrefs);
    logic [31:0] status;
    setup_search(nbands, nrefs);
    write_reg(`HSID_REG_CTRL, 32'h1);
    for (int r = 0; r < nrefs; r++)
      push_reference(r, nbands);
    wait_status(2'b11, "search result", status);  // Idle and result_valid
    check_result(nrefs, nbands);
  endtask

  initial begin
    logic [31:0] status;
    void'($urandom(32'hff33));
    arst_n        = 1'b0;
    cyc           = 1'b0;
    stb           = 1'b0;
    we            = 1'b0;
    adr           = '0;
    dat_w         = '0;
    checks        = 0;
    errors        = 0;
    test_no       = 1;
    test_errors   = 0;
    last_ack_wait = 0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;

    read_reg(`HSID_REG_STATUS, status);  // Idle with no result yet
    expect_word("status", status, 32'h1);
    expect_word("ack_wait", 32'(last_ack_wait), 32'h1);
    finish_test("reset_state");

    fill_random(4);
    for (int b = 0; b < MAX_BANDS; b++)
      ref_s[2][b] = capt_s[b];  // Exact match at index 2
    full_run(8, 4);
    read_reg(`HSID_REG_SCORE_LO, status);
    expect_word("score_lo", status, 32'h0);
    finish_test("basic_search");

    fill_random(4);
    full_run(5, 4);  // Tail lane masked
    finish_test("odd_bands");

    fill_random(6);
    setup_search(16, 6);
    push_reference(0, 16);  // Eight packs fill the FIFO while idle
    probe_stall();
    write_reg(`HSID_REG_CTRL, 32'h1);
    for (int r = 1; r < 6; r++)
      push_reference(r, 16);
    wait_status(2'b11, "back-pressure result", status);
    check_result(6, 16);
    finish_test("back_pressure");

    fill_random(4);
    setup_search(8, 4);
    write_reg(`HSID_REG_CTRL, 32'h1);
    push_reference(0, 4);  // First two packs of reference 0 only
    write_reg(`HSID_REG_CTRL, 32'h2);
    wait_status(2'b01, "idle after clear", status);
    expect_word("status", status, 32'h1);
    fill_random(4);
    for (int b = 0; b < MAX_BANDS; b++)
      ref_s[0][b] = capt_s[b];  // A leftover partial sum would spoil this match
    full_run(8, 4);
    finish_test("clear_mid_run");

    fill_random(3);
    setup_search(6, 3);
    write_reg(`HSID_REG_CTRL, 32'h1);
    for (int r = 0; r < 3; r++) begin
      read_reg(`HSID_REG_STATUS, status);
      expect_word("result_valid", 32'(status[1]), 32'h0);  // Stale result gone
      push_reference(r, 6);
    end
    wait_status(2'b11, "restart result", status);
    check_result(3, 6);
    finish_test("restart_clears_valid");

    $display("summary: %0d tests, %0d checks, %0d errors", test_no - 1, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
+incdir+sim
logic/hsid_pkg.sv
logic/hsid_wb_regs.sv
logic/hsid_captured_buf.sv
logic/hsid_fifo.sv
logic/hsid_main_fsm.sv
logic/hsid_mse_unit.sv
logic/hsid_min_select.sv
logic/hsid_top.sv
sim/hsid_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module hsid_tb -o hsid_sim

out=$(./obj_dir/hsid_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
